//--- md5_params.svh
`ifndef MD5_PARAMS_SVH
`define MD5_PARAMS_SVH

// **************************************************
// MD5 engine sizing
// **************************************************

// width of one state word
`define MD5_WORD_W 32

// steps in one compression
`define MD5_STEPS 64

// standard chaining values for the first block
`define MD5_IV_A 32'h67452301
`define MD5_IV_B 32'hefcdab89
`define MD5_IV_C 32'h98badcfe
`define MD5_IV_D 32'h10325476

// edges from input acceptance to the edge that samples outValid high
// (64 step registers plus the output register, when never stalled)
`define MD5_LATENCY 65

`endif

//--- md5CorePkg.sv
`default_nettype none

`include "md5_params.svh"

package md5CorePkg;

  // one state word, read as a number or as its bytes
  typedef union packed {
    logic [`MD5_WORD_W-1:0] value;
    logic [3:0][7:0]        bytes;
  } md5WordT;

  // boolean function used by a step
  typedef enum logic [1:0] {
    roundF,
    roundG,
    roundH,
    roundI
  } md5RoundT;

  // **************************************************
  // per-step lookup tables
  // **************************************************

  // sine-derived additive constants
  localparam logic [`MD5_WORD_W-1:0] kTable [`MD5_STEPS] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // rotate amounts, four per round, repeating every four steps
  localparam int shiftTable [16] = '{
    7, 12, 17, 22,
    5,  9, 14, 20,
    4, 11, 16, 23,
    6, 10, 15, 21
  };

  function automatic logic [`MD5_WORD_W-1:0] stepConst(input int idx);
    return kTable[idx];
  endfunction

  function automatic int stepShift(input int idx);
    return shiftTable[(idx / 16) * 4 + (idx % 4)];
  endfunction

  function automatic md5RoundT stepRound(input int idx);
    md5RoundT sel;
    case (idx / 16)
      0: sel = roundF;
      1: sel = roundG;
      2: sel = roundH;
      default: sel = roundI;
    endcase
    return sel;
  endfunction

  // message word 0 is the only nonzero word, used once per round
  function automatic bit stepUsesCounter(input int idx);
    return (idx == 0) || (idx == 19) || (idx == 41) || (idx == 48);
  endfunction

endpackage

`default_nettype wire

//--- md5StreamPkg.sv
`default_nettype none

`include "md5_params.svh"

package md5StreamPkg;

  // search counter, becomes message word 0
  typedef logic [`MD5_WORD_W-1:0] counterT;

  // A in the top word down to D in the bottom word
  typedef logic [3:0][`MD5_WORD_W-1:0] digestT;

endpackage

`default_nettype wire

//--- md5Step.sv
`default_nettype none

`include "md5_params.svh"

module md5Step
  import md5CorePkg::*;
  import md5StreamPkg::*;
#(
  parameter int stepIdx = 0
) (
  input  logic    CLK,
  input  logic    arstN,
  input  logic    enable,
  input  logic    validIn,
  input  md5WordT aIn,
  input  md5WordT bIn,
  input  md5WordT cIn,
  input  md5WordT dIn,
  input  counterT counterIn,
  output logic    validOut,
  output md5WordT aOut,
  output md5WordT bOut,
  output md5WordT cOut,
  output md5WordT dOut,
  output counterT counterOut
);

  // step constants resolved at elaboration
  localparam md5RoundT roundSel = stepRound(stepIdx);
  localparam logic [`MD5_WORD_W-1:0] kConst = stepConst(stepIdx);
  localparam int shiftAmt = stepShift(stepIdx);
  localparam bit useCounter = stepUsesCounter(stepIdx);

  logic [`MD5_WORD_W-1:0] fVal;
  logic [`MD5_WORD_W-1:0] msgVal;
  logic [`MD5_WORD_W-1:0] sumVal;
  logic [`MD5_WORD_W-1:0] rotVal;

  // round function
  always_comb
  begin
    case (roundSel)
      roundF: fVal = (bIn.value & cIn.value) | (~bIn.value & dIn.value);
      roundG: fVal = (dIn.value & bIn.value) | (~dIn.value & cIn.value);
      roundH: fVal = bIn.value ^ cIn.value ^ dIn.value;
      default: fVal = cIn.value ^ (bIn.value | ~dIn.value);
    endcase
  end

  // all other message words are zero
  assign msgVal = useCounter ? counterIn : '0;
  assign sumVal = aIn.value + fVal + kConst + msgVal;
  assign rotVal = (sumVal << shiftAmt) | (sumVal >> (`MD5_WORD_W - shiftAmt));

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      validOut <= 1'b0;
    end
    else if (enable)
    begin
      validOut <= validIn;
    end
  end

  // state rotates one word per step
  always_ff @(posedge CLK)
  begin
    if (enable)
    begin
      aOut       <= dIn;
      bOut.value <= bIn.value + rotVal;
      cOut       <= bIn;
      dOut       <= cIn;
      counterOut <= counterIn;
    end
  end

endmodule

`default_nettype wire

//--- md5StepChain.sv
`default_nettype none

`include "md5_params.svh"

module md5StepChain
  import md5CorePkg::*;
  import md5StreamPkg::*;
(
  input  logic    CLK,
  input  logic    arstN,
  input  logic    enable,
  input  logic    validIn,
  input  counterT counterIn,
  output logic    validOut,
  output md5WordT aOut,
  output md5WordT bOut,
  output md5WordT cOut,
  output md5WordT dOut,
  output counterT counterOut
);

  // index k is the input of step k, the last entry leaves the chain
  logic    validW   [`MD5_STEPS + 1];
  md5WordT aW       [`MD5_STEPS + 1];
  md5WordT bW       [`MD5_STEPS + 1];
  md5WordT cW       [`MD5_STEPS + 1];
  md5WordT dW       [`MD5_STEPS + 1];
  counterT counterW [`MD5_STEPS + 1];

  // single block, so step 0 starts from the chaining constants
  assign validW[0]   = validIn;
  assign aW[0]       = `MD5_IV_A;
  assign bW[0]       = `MD5_IV_B;
  assign cW[0]       = `MD5_IV_C;
  assign dW[0]       = `MD5_IV_D;
  assign counterW[0] = counterIn;

  for (genvar i = 0; i < `MD5_STEPS; i++)
  begin : gStep
    md5Step #(
      .stepIdx(i)
    ) uStep (
      .CLK       (CLK),
      .arstN     (arstN),
      .enable    (enable),
      .validIn   (validW[i]),
      .aIn       (aW[i]),
      .bIn       (bW[i]),
      .cIn       (cW[i]),
      .dIn       (dW[i]),
      .counterIn (counterW[i]),
      .validOut  (validW[i + 1]),
      .aOut      (aW[i + 1]),
      .bOut      (bW[i + 1]),
      .cOut      (cW[i + 1]),
      .dOut      (dW[i + 1]),
      .counterOut(counterW[i + 1])
    );
  end

  assign validOut   = validW[`MD5_STEPS];
  assign aOut       = aW[`MD5_STEPS];
  assign bOut       = bW[`MD5_STEPS];
  assign cOut       = cW[`MD5_STEPS];
  assign dOut       = dW[`MD5_STEPS];
  assign counterOut = counterW[`MD5_STEPS];

endmodule

`default_nettype wire

//--- md5Finalize.sv
`default_nettype none

`include "md5_params.svh"

module md5Finalize
  import md5CorePkg::*;
  import md5StreamPkg::*;
(
  input  logic    CLK,
  input  logic    arstN,
  input  logic    validIn,
  input  md5WordT aIn,
  input  md5WordT bIn,
  input  md5WordT cIn,
  input  md5WordT dIn,
  input  counterT counterIn,
  input  logic    outReady,
  output logic    advance,
  output logic    outValid,
  output digestT  digest,
  output counterT counterOut
);

  // add chaining value, then emit the word little endian
  function automatic md5WordT finishWord(input md5WordT w,
                                         input logic [`MD5_WORD_W-1:0] iv);
    md5WordT sum;
    md5WordT swapped;
    sum.value = w.value + iv;
    for (int i = 0; i < 4; i++)
    begin
      swapped.bytes[i] = sum.bytes[3 - i];
    end
    return swapped;
  endfunction

  md5WordT aFin;
  md5WordT bFin;
  md5WordT cFin;
  md5WordT dFin;

  assign aFin = finishWord(aIn, `MD5_IV_A);
  assign bFin = finishWord(bIn, `MD5_IV_B);
  assign cFin = finishWord(cIn, `MD5_IV_C);
  assign dFin = finishWord(dIn, `MD5_IV_D);

  // **************************************************
  // global stall
  // **************************************************

  // whole pipe moves only if the output slot frees up this cycle
  assign advance = ~outValid | outReady;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      outValid <= 1'b0;
    end
    else if (advance)
    begin
      outValid <= validIn;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (advance)
    begin
      digest     <= {aFin.value, bFin.value, cFin.value, dFin.value};
      counterOut <= counterIn;
    end
  end

endmodule

`default_nettype wire

//--- counterHashPipe.sv
`default_nettype none

module counterHashPipe
  import md5CorePkg::*;
  import md5StreamPkg::*;
(
  input  logic    CLK,
  input  logic    arstN,
  input  logic    inValid,
  input  counterT counterIn,
  output logic    inReady,
  input  logic    outReady,
  output logic    outValid,
  output digestT  digest,
  output counterT counterOut
);

  logic    advance;
  logic    chainValid;
  md5WordT chainA;
  md5WordT chainB;
  md5WordT chainC;
  md5WordT chainD;
  counterT chainCounter;

  // accept whenever the pipe is moving
  assign inReady = advance;

  // **************************************************
  // 64 registered steps
  // **************************************************

  md5StepChain uChain (
    .CLK       (CLK),
    .arstN     (arstN),
    .enable    (advance),
    .validIn   (inValid),
    .counterIn (counterIn),
    .validOut  (chainValid),
    .aOut      (chainA),
    .bOut      (chainB),
    .cOut      (chainC),
    .dOut      (chainD),
    .counterOut(chainCounter)
  );

  // output register and stall source
  md5Finalize uFinal (
    .CLK       (CLK),
    .arstN     (arstN),
    .validIn   (chainValid),
    .aIn       (chainA),
    .bIn       (chainB),
    .cIn       (chainC),
    .dIn       (chainD),
    .counterIn (chainCounter),
    .outReady  (outReady),
    .advance   (advance),
    .outValid  (outValid),
    .digest    (digest),
    .counterOut(counterOut)
  );

endmodule

`default_nettype wire

//--- counterHashPipe_checker.sv
`default_nettype none

module counterHashPipe_checker
  import md5StreamPkg::*;
(
  input logic    CLK,
  input logic    arstN,
  input logic    inReady,
  input logic    outValid,
  input logic    outReady,
  input digestT  digest,
  input counterT counterOut
);

  // **************************************************
  // output handshake
  // **************************************************

  // a waiting result stays put until the sink takes it
  aHoldWhileStalled: assert property (@(posedge CLK) disable iff (!arstN)
    (outValid && !outReady) |=> (outValid && $stable(digest) && $stable(counterOut)))
    else $error("digest or counterOut changed while the sink stalled");

  // single global stall
  aReadyRule: assert property (@(posedge CLK) disable iff (!arstN)
    inReady == (!outValid || outReady))
    else $error("inReady does not follow the stall rule");

  aValidKnown: assert property (@(posedge CLK) disable iff (!arstN)
    !$isunknown(outValid))
    else $error("outValid is unknown");

endmodule

bind counterHashPipe counterHashPipe_checker uChecker (
  .CLK       (CLK),
  .arstN     (arstN),
  .inReady   (inReady),
  .outValid  (outValid),
  .outReady  (outReady),
  .digest    (digest),
  .counterOut(counterOut)
);

`default_nettype wire

//--- tbMd5Model.svh
`ifndef TB_MD5_MODEL_SVH
`define TB_MD5_MODEL_SVH

`include "md5_params.svh"

// **************************************************
// reference MD5 of one counter block
// **************************************************

// swap to little endian byte order
function automatic logic [31:0] byteSwap(input logic [31:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// word 0 holds the counter, words 1 to 15 are zero, no padding
function automatic logic [127:0] md5CounterDigest(input logic [31:0] counter);
  logic [31:0] msg [16];
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  logic [31:0] f;
  logic [31:0] sum;
  logic [31:0] oldD;
  logic [3:0]  g;
  int          s;
  for (int w = 0; w < 16; w++)
  begin
    msg[w] = 32'h0;
  end
  msg[0] = counter;
  a = `MD5_IV_A;
  b = `MD5_IV_B;
  c = `MD5_IV_C;
  d = `MD5_IV_D;
  for (int i = 0; i < 64; i++)
  begin
    // boolean function and message schedule per round
    if (i < 16)
    begin
      f = (b & c) | (~b & d);
      g = 4'(i);
    end
    else if (i < 32)
    begin
      f = (d & b) | (~d & c);
      g = 4'((5 * i + 1) % 16);
    end
    else if (i < 48)
    begin
      f = b ^ c ^ d;
      g = 4'((3 * i + 5) % 16);
    end
    else
    begin
      f = c ^ (b | ~d);
      g = 4'((7 * i) % 16);
    end
    sum  = a + f + stepConst(i) + msg[g];
    s    = stepShift(i);
    oldD = d;
    d    = c;
    c    = b;
    b    = b + ((sum << s) | (sum >> (32 - s)));
    a    = oldD;
  end
  return {byteSwap(a + `MD5_IV_A), byteSwap(b + `MD5_IV_B),
          byteSwap(c + `MD5_IV_C), byteSwap(d + `MD5_IV_D)};
endfunction

`endif

//--- counterHashPipe_tb.sv
`default_nettype none

`include "md5_params.svh"

module counterHashPipe_tb
  import md5CorePkg::*;
  import md5StreamPkg::*;
;

  `include "tbMd5Model.svh"

  localparam int numEntries = 44;

  logic    CLK;
  logic    arstN;
  logic    inValid;
  counterT counterIn;
  logic    inReady;
  logic    outReady;
  logic    outValid;
  digestT  digest;
  counterT counterOut;

  // stimulus table with expected results
  logic [31:0]  counterTab  [numEntries];
  int           gapTab      [numEntries];
  int           stallTab    [numEntries];
  logic [127:0] expectTab   [numEntries];
  int           acceptCycle [numEntries];
  int           pendingQ    [$];

  counterHashPipe uut (
    .CLK       (CLK),
    .arstN     (arstN),
    .inValid   (inValid),
    .counterIn (counterIn),
    .inReady   (inReady),
    .outReady  (outReady),
    .outValid  (outValid),
    .digest    (digest),
    .counterOut(counterOut)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    if (got !== exp)
    begin
      abortRun($sformatf("error at time %0t: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  // **************************************************
  // table contents
  // **************************************************

  task automatic fillTable();
    for (int i = 0; i < numEntries; i++)
    begin
      counterTab[i] = $urandom;
      gapTab[i]     = 0;
      stallTab[i]   = 0;
      // 2..11 back to back, 12..23 input gaps, the rest sink stalls too
      if (i >= 12)
      begin
        gapTab[i] = (i < 24) ? int'($urandom % 4) : int'($urandom % 3);
      end
      if (i >= 24)
      begin
        stallTab[i] = int'($urandom % 4);
      end
    end
    // two lone counters with the second sent after the first has drained
    counterTab[0] = 32'h0000_0000;
    counterTab[1] = 32'hffff_ffff;
    gapTab[1]     = 70;
    gapTab[2]     = 3;
    for (int i = 0; i < numEntries; i++)
    begin
      expectTab[i] = md5CounterDigest(counterTab[i]);
    end
  endtask

  initial
  begin
    int  inIdx;
    int  outCount;
    int  gapLeft;
    int  stallLeft;
    int  cycle;
    int  limit;
    int  idx;
    bit  stalled;
    inValid   = 1'b0;
    counterIn = '0;
    outReady  = 1'b1;
    arstN     = 1'b0;
    void'($urandom(55346));
    fillTable();
    limit = 4 * numEntries + 3 * `MD5_LATENCY;
    for (int i = 0; i < numEntries; i++)
    begin
      limit += stallTab[i];
    end
    inIdx     = 0;
    outCount  = 0;
    gapLeft   = gapTab[0];
    stallLeft = stallTab[0];
    cycle     = 0;
    stalled   = 1'b0;

    repeat (2) @(negedge CLK);
    arstN = 1'b1;
    #1;
    checkValue("outValid", 128'(outValid), 128'(1'b0));
    checkValue("inReady", 128'(inReady), 128'(1'b1));

    while (outCount < numEntries)
    begin
      @(negedge CLK);
      cycle++;
      if (cycle > limit)
      begin
        abortRun($sformatf("timeout after %0d cycles with %0d of %0d digests returned",
                           cycle, outCount, numEntries));
      end
      // sink drops ready while its stall budget lasts
      // only a waiting result uses up that budget
      if (stallLeft > 0)
      begin
        outReady = 1'b0;
        if (outValid)
        begin
          stallLeft--;
          stalled = 1'b1;
        end
      end
      else
      begin
        outReady = 1'b1;
      end
      if (inIdx < numEntries && gapLeft == 0)
      begin
        inValid   = 1'b1;
        counterIn = counterTab[inIdx];
      end
      else
      begin
        inValid = 1'b0;
        if (inIdx < numEntries)
        begin
          gapLeft--;
        end
      end
      #1;
      checkValue("inReady", 128'(inReady), 128'(!outValid || outReady));
      if (inValid && inReady)
      begin
        pendingQ.push_back(inIdx);
        acceptCycle[inIdx] = cycle;
        inIdx++;
        if (inIdx < numEntries)
        begin
          gapLeft = gapTab[inIdx];
        end
      end
      if (outValid && outReady)
      begin
        if (pendingQ.size() == 0)
        begin
          abortRun("a digest came out with no counter in flight");
        end
        idx = pendingQ.pop_front();
        checkValue("counterOut", 128'(counterOut), 128'(counterTab[idx]));
        checkValue("digest", digest, expectTab[idx]);
        // fixed latency holds until the first stall
        if (!stalled)
        begin
          checkValue("latency", 128'(cycle - acceptCycle[idx]), 128'(`MD5_LATENCY));
        end
        outCount++;
        if (outCount < numEntries)
        begin
          stallLeft = stallTab[outCount];
        end
      end
    end

    // nothing may follow the last result
    outReady = 1'b1;
    repeat (`MD5_LATENCY)
    begin
      @(negedge CLK);
      #1;
      checkValue("outValid", 128'(outValid), 128'(1'b0));
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- counterHashPipe.f
+incdir+.
md5CorePkg.sv
md5StreamPkg.sv
md5Step.sv
md5StepChain.sv
md5Finalize.sv
counterHashPipe.sv
counterHashPipe_checker.sv
counterHashPipe_tb.sv

//--- Makefile
# Verilator flow for the counter hash pipeline

VERILATOR ?= verilator
TOP       ?= counterHashPipe_tb
FILELIST  ?= counterHashPipe.f
OBJDIR    ?= obj_dir
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
